// ==== Makefile ====
TOOL     = verilator
TOP      = tb_lsu
FILELIST = tb.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FLAGS    = --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -Mdir $(OBJ_DIR)
FAIL_MSG = sim failed
PASS_MSG = sim passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) -f $(FILELIST)

# The log decides the result, not the simulator exit status
run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "FAIL: failure reported in $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "FAIL: run ended without a result in $(LOG)"; exit 1; \
	else \
	  echo "PASS"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== logic/address_adder.sv ====
// Address generation stage with byte enables, store lane shift, alignment and range checks
module address_adder (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               req_valid_i,
  output logic               req_ready_o,
  input  lsu_pkg::lsu_req_t  req_i,
  output logic               out_valid_o,
  input  logic               out_ready_i,
  output lsu_pkg::addr_req_t out_o
);
  import lsu_pkg::*;

  logic [XLEN-1:0] eff_addr;
  logic [1:0]      byte_off;
  logic [3:0]      be_base;
  logic            misaligned;
  logic            out_of_range;
  except_code_t    except_d;
  addr_req_t       out_d;
  logic            valid_q;
  addr_req_t       out_q;

  // --------------------------------------------------
  // Effective address and checks
  // --------------------------------------------------
  assign eff_addr     = req_i.base + req_i.offset;
  assign byte_off     = eff_addr[1:0];
  assign out_of_range = (eff_addr >= DMEM_BYTES);

  always_comb begin
    case (req_i.width)
      LS_B, LS_BU: begin
        be_base    = 4'b0001;
        misaligned = 1'b0;
      end
      LS_H, LS_HU: begin
        be_base    = 4'b0011;
        misaligned = byte_off[0];
      end
      default: begin
        be_base    = 4'b1111;
        misaligned = |byte_off;
      end
    endcase
  end

  // Misalignment takes priority over an access fault
  always_comb begin
    if (misaligned) begin
      except_d = req_i.is_store ? EXC_ST_MISALIGN : EXC_LD_MISALIGN;
    end else if (out_of_range) begin
      except_d = req_i.is_store ? EXC_ST_FAULT : EXC_LD_FAULT;
    end else begin
      except_d = EXC_NONE;
    end
  end

  always_comb begin
    out_d.is_store = req_i.is_store;
    out_d.width    = req_i.width;
    out_d.addr     = eff_addr;
    // No lanes enabled for a faulting access
    out_d.be       = (except_d == EXC_NONE) ? (be_base << byte_off) : 4'b0000;
    out_d.wdata    = req_i.wdata << {byte_off, 3'b000};
    out_d.tag      = req_i.tag;
    out_d.except   = except_d;
  end

  // --------------------------------------------------
  // Output register
  // --------------------------------------------------
  assign req_ready_o = ~valid_q | out_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (req_ready_o) begin
      valid_q <= req_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      out_q <= out_d;
    end
  end

  assign out_valid_o = valid_q;
  assign out_o       = out_q;

  // Held item must not change until the memory stage takes it
  a_out_stable : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (out_valid_o && !out_ready_i) |=> $stable(out_o));

endmodule

// ==== logic/dmem_access.sv ====
// Memory access stage with the data memory array, byte-enabled writes and word reads
module dmem_access (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               in_valid_i,
  output logic               in_ready_o,
  input  lsu_pkg::addr_req_t in_i,
  output logic               out_valid_o,
  input  logic               out_ready_i,
  output lsu_pkg::mem_rsp_t  out_o
);
  import lsu_pkg::*;

  // Word storage, contents undefined until written
  logic [XLEN-1:0]       mem_q [DMEM_WORDS];

  logic                  in_fire;
  logic                  mem_we;
  logic [DMEM_IDX_W-1:0] word_idx;
  logic                  valid_q;
  mem_rsp_t              out_q;

  // --------------------------------------------------
  // Handshake
  // --------------------------------------------------
  assign in_ready_o = ~valid_q | out_ready_i;
  assign in_fire    = in_valid_i & in_ready_o;

  // Word index from the byte address
  assign word_idx = in_i.addr[DMEM_IDX_W+1:2];

  // Only clean stores reach the array
  assign mem_we = in_fire & in_i.is_store & (in_i.except == EXC_NONE);

  // --------------------------------------------------
  // Data memory
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    for (int b = 0; b < 4; b++) begin
      if (mem_we && in_i.be[b]) begin
        mem_q[word_idx][8*b +: 8] <= in_i.wdata[8*b +: 8];
      end
    end
  end

  // --------------------------------------------------
  // Response register
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  // Read sees every store accepted on an earlier edge
  always_ff @(posedge clk_i) begin
    if (in_fire) begin
      out_q.is_store <= in_i.is_store;
      out_q.width    <= in_i.width;
      out_q.byte_off <= in_i.addr[1:0];
      out_q.rdata    <= mem_q[word_idx];
      out_q.tag      <= in_i.tag;
      out_q.except   <= in_i.except;
    end
  end

  assign out_valid_o = valid_q;
  assign out_o       = out_q;

  // Faulting requests neither write nor carry byte enables from address generation
  a_no_fault_write : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (in_valid_i && in_i.except != EXC_NONE) |-> (!mem_we && in_i.be == 4'b0000));

endmodule

// ==== logic/load_align.sv ====
// Load alignment stage with byte and halfword selection, extension and response register
module load_align (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              in_valid_i,
  output logic              in_ready_o,
  input  lsu_pkg::mem_rsp_t in_i,
  output logic              rsp_valid_o,
  input  logic              rsp_ready_i,
  output lsu_pkg::lsu_rsp_t rsp_o
);
  import lsu_pkg::*;

  logic [XLEN-1:0] shifted;
  logic [XLEN-1:0] ext_data;
  lsu_rsp_t        rsp_d;
  logic            valid_q;
  lsu_rsp_t        rsp_q;

  // --------------------------------------------------
  // Lane selection and extension
  // --------------------------------------------------

  // Move the addressed lane down to bit 0
  assign shifted = in_i.rdata >> {in_i.byte_off, 3'b000};

  always_comb begin
    case (in_i.width)
      LS_B:    ext_data = {{24{shifted[7]}}, shifted[7:0]};
      LS_BU:   ext_data = {24'h000000, shifted[7:0]};
      LS_H:    ext_data = {{16{shifted[15]}}, shifted[15:0]};
      LS_HU:   ext_data = {16'h0000, shifted[15:0]};
      default: ext_data = in_i.rdata;
    endcase
  end

  always_comb begin
    rsp_d.tag      = in_i.tag;
    rsp_d.is_store = in_i.is_store;
    rsp_d.except   = in_i.except;
    // Stores and faults return zero
    if (in_i.is_store || in_i.except != EXC_NONE) begin
      rsp_d.data = '0;
    end else begin
      rsp_d.data = ext_data;
    end
  end

  // --------------------------------------------------
  // Response register
  // --------------------------------------------------
  assign in_ready_o = ~valid_q | rsp_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      rsp_q <= rsp_d;
    end
  end

  assign rsp_valid_o = valid_q;
  assign rsp_o       = rsp_q;

  // Valid chain from all three stages stays known once out of reset
  a_valid_known : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !$isunknown(rsp_valid_o));

endmodule

// ==== logic/lsu_pkg.sv ====
// Shared widths, memory size, access and exception encodings, stage payload structs
package lsu_pkg;

  // --------------------------------------------------
  // Widths and sizes
  // --------------------------------------------------

  // Data and address width
  localparam int unsigned XLEN       = 32;
  // Local data memory, in 32-bit words
  localparam int unsigned DMEM_WORDS = 64;
  localparam int unsigned DMEM_IDX_W = 6;
  // First byte address that faults
  localparam int unsigned DMEM_BYTES = DMEM_WORDS * 4;
  // Request tag
  localparam int unsigned TAG_W      = 4;

  // --------------------------------------------------
  // Encodings
  // --------------------------------------------------

  // Access width and signedness
  typedef enum logic [2:0] {
    LS_B,
    LS_BU,
    LS_H,
    LS_HU,
    LS_W
  } ldst_width_t;

  // RISC-V exception causes for memory accesses
  typedef enum logic [3:0] {
    EXC_NONE        = 4'd0,
    EXC_LD_MISALIGN = 4'd4,
    EXC_LD_FAULT    = 4'd5,
    EXC_ST_MISALIGN = 4'd6,
    EXC_ST_FAULT    = 4'd7
  } except_code_t;

  // --------------------------------------------------
  // Stage payloads
  // --------------------------------------------------

  // Request from the issue side
  typedef struct packed {
    logic             is_store;
    ldst_width_t      width;
    logic [XLEN-1:0]  base;
    logic [XLEN-1:0]  offset;
    logic [XLEN-1:0]  wdata;
    logic [TAG_W-1:0] tag;
  } lsu_req_t;

  // Address generation result, store data already in its byte lanes
  typedef struct packed {
    logic             is_store;
    ldst_width_t      width;
    logic [XLEN-1:0]  addr;
    logic [3:0]       be;
    logic [XLEN-1:0]  wdata;
    logic [TAG_W-1:0] tag;
    except_code_t     except;
  } addr_req_t;

  // Memory stage result with the raw word
  typedef struct packed {
    logic             is_store;
    ldst_width_t      width;
    logic [1:0]       byte_off;
    logic [XLEN-1:0]  rdata;
    logic [TAG_W-1:0] tag;
    except_code_t     except;
  } mem_rsp_t;

  // Final response
  typedef struct packed {
    logic [TAG_W-1:0] tag;
    logic [XLEN-1:0]  data;
    logic             is_store;
    except_code_t     except;
  } lsu_rsp_t;

endpackage

// ==== logic/lsu_top.sv ====
// Load-store pipeline top level joining address, memory and alignment stages
module lsu_top (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  lsu_pkg::lsu_req_t req_i,
  output logic              rsp_valid_o,
  input  logic              rsp_ready_i,
  output lsu_pkg::lsu_rsp_t rsp_o
);
  import lsu_pkg::*;

  // --------------------------------------------------
  // Inter-stage links
  // --------------------------------------------------

  // Address generation to memory
  logic      addr_valid;
  logic      addr_ready;
  addr_req_t addr_req;

  // Memory to load alignment
  logic      mem_valid;
  logic      mem_ready;
  mem_rsp_t  mem_rsp;

  // --------------------------------------------------
  // Stages
  // --------------------------------------------------
  address_adder u_address_adder (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_valid_i(req_valid_i),
    .req_ready_o(req_ready_o),
    .req_i      (req_i),
    .out_valid_o(addr_valid),
    .out_ready_i(addr_ready),
    .out_o      (addr_req)
  );

  dmem_access u_dmem_access (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .in_valid_i (addr_valid),
    .in_ready_o (addr_ready),
    .in_i       (addr_req),
    .out_valid_o(mem_valid),
    .out_ready_i(mem_ready),
    .out_o      (mem_rsp)
  );

  load_align u_load_align (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .in_valid_i (mem_valid),
    .in_ready_o (mem_ready),
    .in_i       (mem_rsp),
    .rsp_valid_o(rsp_valid_o),
    .rsp_ready_i(rsp_ready_i),
    .rsp_o      (rsp_o)
  );

endmodule

// ==== tb.f ====
logic/lsu_pkg.sv
logic/address_adder.sv
logic/dmem_access.sv
logic/load_align.sv
logic/lsu_top.sv
test/tb_lsu.sv

// ==== test/tb_lsu.sv ====
// Testbench for the load-store pipeline with reference memory, response monitor and directed tests
module tb_lsu;
  timeunit 1ns;
  timeprecision 1ps;

  import lsu_pkg::*;

  localparam int unsigned SEED           = 32'h04af2698;
  // Roughly 400 requests with stalls, times a margin
  localparam int          TIMEOUT_CYCLES = 2000;
  // Settling delay after the falling edge before outputs are read
  localparam int          SETTLE         = 1;

  logic     clk_i;
  logic     rst_n_i;
  logic     req_valid_i;
  logic     req_ready_o;
  lsu_req_t req_i;
  logic     rsp_valid_o;
  logic     rsp_ready_i = 1'b1;
  lsu_rsp_t rsp_o;

  // Byte-wide reference memory and expected responses in program order
  logic [7:0]  ref_mem [256];
  lsu_rsp_t    exp_q [$];
  lsu_rsp_t    exp_rsp;
  logic        stall_en;
  int          cycle_cnt = 0;
  int          rsp_count = 0;

  lsu_top i_dut (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_valid_i(req_valid_i),
    .req_ready_o(req_ready_o),
    .req_i      (req_i),
    .rsp_valid_o(rsp_valid_o),
    .rsp_ready_i(rsp_ready_i),
    .rsp_o      (rsp_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // --------------------------------------------------
  // Checking helpers
  // --------------------------------------------------
  task automatic stop_with_failure();
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
    if (actual !== expected) begin
      $display("mismatch %s: got %h expected %h", name, actual, expected);
      stop_with_failure();
    end
  endtask

  // Reference model of one request, applied in program order
  task automatic predict(input lsu_req_t r, output lsu_rsp_t e);
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] raw;
    logic [7:0]      idx;
    int              nbytes;
    addr = r.base + r.offset;
    case (r.width)
      LS_B, LS_BU: nbytes = 1;
      LS_H, LS_HU: nbytes = 2;
      default:     nbytes = 4;
    endcase
    e.tag      = r.tag;
    e.is_store = r.is_store;
    e.data     = '0;
    e.except   = EXC_NONE;
    if ((addr[1:0] & 2'(nbytes - 1)) != 2'b00) begin
      e.except = r.is_store ? EXC_ST_MISALIGN : EXC_LD_MISALIGN;
    end else if (addr >= 32'd256) begin
      e.except = r.is_store ? EXC_ST_FAULT : EXC_LD_FAULT;
    end else if (r.is_store) begin
      for (int i = 0; i < nbytes; i++) begin
        idx = addr[7:0] + 8'(i);
        ref_mem[idx] = r.wdata[7:0];
        r.wdata = r.wdata >> 8;
      end
    end else begin
      raw = '0;
      for (int i = 0; i < nbytes; i++) begin
        idx = addr[7:0] + 8'(i);
        raw = raw | (32'(ref_mem[idx]) << (8 * i));
      end
      case (r.width)
        LS_B:    e.data = {{24{raw[7]}}, raw[7:0]};
        LS_H:    e.data = {{16{raw[15]}}, raw[15:0]};
        default: e.data = raw;
      endcase
    end
  endtask

  // --------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------
  function automatic lsu_req_t make_req(input logic st, input ldst_width_t w,
                                        input logic [XLEN-1:0] base,
                                        input logic [XLEN-1:0] off,
                                        input logic [XLEN-1:0] wdata,
                                        input logic [TAG_W-1:0] tag);
    lsu_req_t r;
    r.is_store = st;
    r.width    = w;
    r.base     = base;
    r.offset   = off;
    r.wdata    = wdata;
    r.tag      = tag;
    return r;
  endfunction

  // Holds valid until ready was seen high before a rising edge
  task automatic send_req(input lsu_req_t r);
    lsu_rsp_t e;
    @(negedge clk_i);
    req_valid_i = 1'b1;
    req_i       = r;
    #SETTLE;
    while (!req_ready_o) begin
      @(negedge clk_i);
      #SETTLE;
    end
    predict(r, e);
    exp_q.push_back(e);
    @(posedge clk_i);
  endtask

  task automatic wait_drain();
    @(negedge clk_i);
    req_valid_i = 1'b0;
    while (exp_q.size() != 0) begin
      @(negedge clk_i);
    end
  endtask

  // Aligned, in-range request with a random base/offset split
  task automatic random_req(input int n, output lsu_req_t r);
    logic [XLEN-1:0] addr;
    r.is_store = 1'($urandom);
    r.width    = ldst_width_t'(3'($urandom_range(4)));
    addr       = 32'($urandom_range(255));
    case (r.width)
      LS_H, LS_HU: addr[0] = 1'b0;
      LS_W:        addr[1:0] = 2'b00;
      default:     addr = addr;
    endcase
    r.base   = $urandom;
    r.offset = addr - r.base;
    r.wdata  = $urandom;
    r.tag    = 4'(n);
  endtask

  // --------------------------------------------------
  // Monitor, back-pressure and timeout
  // --------------------------------------------------
  always @(negedge clk_i) begin
    #SETTLE;
    if (rst_n_i && rsp_valid_o && rsp_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("unexpected response with tag %h while no request is outstanding", rsp_o.tag);
        stop_with_failure();
      end else begin
        exp_rsp = exp_q.pop_front();
        check_val("rsp_o.tag", 32'(rsp_o.tag), 32'(exp_rsp.tag));
        check_val("rsp_o.is_store", 32'(rsp_o.is_store), 32'(exp_rsp.is_store));
        check_val("rsp_o.except", 32'(rsp_o.except), 32'(exp_rsp.except));
        check_val("rsp_o.data", rsp_o.data, exp_rsp.data);
        rsp_count = rsp_count + 1;
      end
    end
  end

  // About one cycle in four stalled
  always @(negedge clk_i) begin
    if (stall_en) begin
      rsp_ready_i = ($urandom_range(3) != 0);
    end else begin
      rsp_ready_i = 1'b1;
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles with %0d responses still outstanding",
               cycle_cnt, exp_q.size());
      stop_with_failure();
    end
  end

  // --------------------------------------------------
  // Directed tests
  // --------------------------------------------------
  task automatic test_reset_latency();
    int lat;
    check_val("rsp_valid_o", 32'(rsp_valid_o), 32'd0);
    check_val("req_ready_o", 32'(req_ready_o), 32'd1);
    send_req(make_req(1'b1, LS_W, 32'h0, 32'h0, 32'h1234_5678, 4'h0));
    wait_drain();
    send_req(make_req(1'b0, LS_W, 32'h0, 32'h0, 32'h0, 4'h1));
    // Transfer edge counts as the first cycle
    lat = 1;
    @(negedge clk_i);
    req_valid_i = 1'b0;
    #SETTLE;
    while (!rsp_valid_o) begin
      @(negedge clk_i);
      #SETTLE;
      lat = lat + 1;
    end
    check_val("latency", 32'(lat), 32'd3);
    wait_drain();
  endtask

  task automatic test_word_store_load();
    logic [XLEN-1:0] bases [5];
    logic [XLEN-1:0] offs [5];
    // Sums 0x00, 0x24, 0xfc, 0x80, 0x08
    bases = '{32'h0000_0000, 32'h0000_0020, 32'h0000_00f0, 32'h0000_0100, 32'h0000_0007};
    offs  = '{32'h0000_0000, 32'h0000_0004, 32'h0000_000c, 32'hffff_ff80, 32'h0000_0001};
    for (int i = 0; i < 5; i++) begin
      send_req(make_req(1'b1, LS_W, bases[i], offs[i], $urandom, 4'(i)));
    end
    // Same addresses with base and offset swapped
    for (int i = 0; i < 5; i++) begin
      send_req(make_req(1'b0, LS_W, offs[i], bases[i], 32'h0, 4'(i + 8)));
    end
    wait_drain();
  endtask

  task automatic test_subword();
    // Word at 0x40 becomes 0xbeef7f80
    send_req(make_req(1'b1, LS_B, 32'h40, 32'h0, 32'h0000_0080, 4'h0));
    send_req(make_req(1'b1, LS_B, 32'h40, 32'h1, 32'h0000_007f, 4'h1));
    send_req(make_req(1'b1, LS_H, 32'h40, 32'h2, 32'h1234_beef, 4'h2));
    send_req(make_req(1'b0, LS_B, 32'h40, 32'h0, 32'h0, 4'h3));
    send_req(make_req(1'b0, LS_BU, 32'h40, 32'h0, 32'h0, 4'h4));
    send_req(make_req(1'b0, LS_B, 32'h40, 32'h1, 32'h0, 4'h5));
    send_req(make_req(1'b0, LS_BU, 32'h40, 32'h3, 32'h0, 4'h6));
    send_req(make_req(1'b0, LS_H, 32'h40, 32'h2, 32'h0, 4'h7));
    send_req(make_req(1'b0, LS_HU, 32'h40, 32'h2, 32'h0, 4'h8));
    send_req(make_req(1'b0, LS_H, 32'h40, 32'h0, 32'h0, 4'h9));
    send_req(make_req(1'b0, LS_W, 32'h40, 32'h0, 32'h0, 4'ha));
    wait_drain();
  endtask

  task automatic test_exceptions();
    send_req(make_req(1'b1, LS_W, 32'h4, 32'h0, 32'h5a5a_a5a5, 4'h0));
    send_req(make_req(1'b1, LS_W, 32'h20, 32'h0, 32'h0f0f_f0f0, 4'h1));
    // Misaligned halfwords and words
    send_req(make_req(1'b0, LS_H, 32'h20, 32'h1, 32'h0, 4'h2));
    send_req(make_req(1'b0, LS_W, 32'h20, 32'h2, 32'h0, 4'h3));
    send_req(make_req(1'b1, LS_HU, 32'h20, 32'h3, 32'hffff_ffff, 4'h4));
    send_req(make_req(1'b1, LS_W, 32'h20, 32'h1, 32'hffff_ffff, 4'h5));
    // Out of range, 0x104 would alias word 1
    send_req(make_req(1'b0, LS_W, 32'h100, 32'h0, 32'h0, 4'h6));
    send_req(make_req(1'b1, LS_W, 32'h100, 32'h4, 32'hdead_beef, 4'h7));
    send_req(make_req(1'b0, LS_B, 32'h1ff, 32'h0, 32'h0, 4'h8));
    send_req(make_req(1'b1, LS_H, 32'hffff_fff0, 32'h2, 32'hcafe_cafe, 4'h9));
    // Both words must still hold their first values
    send_req(make_req(1'b0, LS_W, 32'h4, 32'h0, 32'h0, 4'ha));
    send_req(make_req(1'b0, LS_W, 32'h20, 32'h0, 32'h0, 4'hb));
    wait_drain();
  endtask

  task automatic test_streaming();
    lsu_req_t r;
    stall_en = 1'b1;
    // Every word written before random loads
    for (int i = 0; i < DMEM_WORDS; i++) begin
      send_req(make_req(1'b1, LS_W, 32'(4 * i), 32'h0, $urandom, 4'(i)));
    end
    for (int i = 0; i < 300; i++) begin
      random_req(i, r);
      send_req(r);
    end
    wait_drain();
    stall_en = 1'b0;
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    void'($urandom(SEED));
    rst_n_i     = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    stall_en    = 1'b0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    test_reset_latency();
    test_word_store_load();
    test_subword();
    test_exceptions();
    test_streaming();
    $display("%0d responses checked in %0d cycles", rsp_count, cycle_cnt);
    $display("sim passed");
    $finish;
  end

endmodule
